// ==== rtl/ahbSwitchPkg.sv ====
/* AHB3-Lite switch shared definitions
   Bus widths, transfer and response codes, and the two-by-two switch size */
package ahbSwitchPkg;

  //////////////////////////////
  // Switch dimensions
  //////////////////////////////

  // Master layers on the switch
  localparam int nMasters = 2;
  // Slave ports on the switch
  localparam int nSlaves = 2;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  // HSIZE is always three bits on AHB
  localparam int sizeWidth = 3;
  // One bit gives a high and a low priority
  localparam int prioWidth = 1;

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] dataT;
  typedef logic [sizeWidth-1:0] sizeT;
  typedef logic [prioWidth-1:0] prioT;

  // One-hot slave select, one bit per slave port
  typedef logic [nSlaves-1:0] slvSelT;
  // Grant and owner vectors, one bit per master layer
  typedef logic [nMasters-1:0] mstSelT;

  //////////////////////////////
  // Bus codes
  //////////////////////////////

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htransT;

  // HRESP encoding of AHB3-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hrespT;

endpackage

// ==== rtl/ahbLayerIf.sv ====
/* Link from one master layer to all slave ports of the switch */
interface ahbLayerIf
  import ahbSwitchPkg::*;
();

  // Request side, driven by the master layer
  slvSelT reqSel;
  addrT   addr;
  dataT   wdata;
  logic   write;
  sizeT   size;
  htransT trans;
  prioT   prio;
  // High once the layer has no data phase left in flight
  logic   busReady;

  // Return side, element s is driven by slave port s
  logic   grant    [nSlaves];
  dataT   rdata    [nSlaves];
  logic   readyOut [nSlaves];
  hrespT  resp     [nSlaves];

  // Master layer view
  modport layer (
    output reqSel, addr, wdata, write, size, trans, prio, busReady,
    input  grant, rdata, readyOut, resp
  );

  // Slave port view
  modport slave (
    input  reqSel, addr, wdata, write, size, trans, prio, busReady,
    output grant, rdata, readyOut, resp
  );

endinterface

// ==== rtl/ahbMasterPort.sv ====
/* AHB switch master layer
   Decodes and holds a master's transfer, answers unmapped ones, returns slave data */
module ahbMasterPort
  import ahbSwitchPkg::*;
(
  input  logic   HCLK,
  input  logic   rstN,

  // AHB master side of the layer
  input  prioT   prio,
  input  logic   hsel,
  input  addrT   haddr,
  input  dataT   hwdata,
  input  logic   hwrite,
  input  sizeT   hsize,
  input  htransT htrans,
  input  logic   hready,
  output dataT   hrdata,
  output logic   hreadyOut,
  output hrespT  hresp,

  // Address map of the slave ports
  input  addrT   addrMask [nSlaves],
  input  addrT   addrBase [nSlaves],

  ahbLayerIf.layer bus
);

  typedef enum logic [2:0] {stIdle, stWait, stData, stErr1, stErr2} stateT;

  stateT  state;
  stateT  stateNext;
  slvSelT hitSel;
  slvSelT reqSel;
  slvSelT ownSel;
  slvSelT grantVec;
  slvSelT readyVec;
  logic   phaseDone;
  logic   newXfer;
  logic   accepted;
  logic   ownReady;
  hrespT  ownResp;
  dataT   ownRdata;

  // Transfer held while its slave is busy with another layer
  slvSelT heldSel;
  addrT   heldAddr;
  logic   heldWrite;
  sizeT   heldSize;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Lowest matching slave wins if windows overlap
  always_comb
  begin
    hitSel = '0;
    for (int s = 0; s < nSlaves; s++)
    begin
      if (hitSel == '0 && (haddr & addrMask[s]) == (addrBase[s] & addrMask[s]))
        hitSel[s] = 1'b1;
    end
  end

  // Layer free to take a new address phase
  assign phaseDone = (state == stIdle) || (state == stErr2) ||
                     (state == stData && ownReady);
  assign newXfer   = phaseDone && hsel && hready && (htrans == NONSEQ);

  // Held request has precedence, it is the only one in flight
  assign reqSel = (state == stWait) ? heldSel : (newXfer ? hitSel : '0);

  //////////////////////////////
  // Request towards the slaves
  //////////////////////////////

  assign bus.reqSel   = reqSel;
  assign bus.addr     = (state == stWait) ? heldAddr : haddr;
  assign bus.write    = (state == stWait) ? heldWrite : hwrite;
  assign bus.size     = (state == stWait) ? heldSize : hsize;
  // Write data belongs to the data phase and comes live from the master
  assign bus.wdata    = hwdata;
  assign bus.trans    = (reqSel != '0) ? NONSEQ : IDLE;
  assign bus.prio     = prio;
  assign bus.busReady = phaseDone || (state == stWait);

  // Gather return side and pick the data-phase owner
  always_comb
  begin
    ownReady = 1'b0;
    ownResp  = OKAY;
    ownRdata = '0;
    for (int s = 0; s < nSlaves; s++)
    begin
      grantVec[s] = bus.grant[s];
      readyVec[s] = bus.readyOut[s];
      if (ownSel[s])
      begin
        ownReady = bus.readyOut[s];
        ownResp  = bus.resp[s];
        ownRdata = bus.rdata[s];
      end
    end
  end

  // Address phase taken by the wanted slave this cycle
  assign accepted = |(reqSel & grantVec & readyVec);

  //////////////////////////////
  // Layer FSM
  //////////////////////////////

  always_comb
  begin
    stateNext = state;
    case (state)
      stWait:
        if (accepted)
          stateNext = stData;
      // Second cycle of the local error response
      stErr1:
        stateNext = stErr2;
      default:
        if (phaseDone)
        begin
          if (!newXfer)
            stateNext = stIdle;
          else if (hitSel == '0)
            stateNext = stErr1;
          else if (accepted)
            stateNext = stData;
          else
            stateNext = stWait;
        end
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      state  <= stIdle;
      ownSel <= '0;
    end
    else
    begin
      state <= stateNext;
      // Owner of the next data phase
      if (accepted)
        ownSel <= reqSel;
    end
  end

  // Capture every new transfer, only read back in stWait
  always_ff @(posedge HCLK)
  begin
    if (newXfer)
    begin
      heldSel   <= hitSel;
      heldAddr  <= haddr;
      heldWrite <= hwrite;
      heldSize  <= hsize;
    end
  end

  //////////////////////////////
  // Response to the master
  //////////////////////////////

  always_comb
  begin
    case (state)
      stWait:
      begin
        hreadyOut = 1'b0;
        hresp     = OKAY;
      end
      stData:
      begin
        hreadyOut = ownReady;
        hresp     = ownResp;
      end
      stErr1:
      begin
        hreadyOut = 1'b0;
        hresp     = ERROR;
      end
      stErr2:
      begin
        hreadyOut = 1'b1;
        hresp     = ERROR;
      end
      default:
      begin
        hreadyOut = 1'b1;
        hresp     = OKAY;
      end
    endcase
  end

  assign hrdata = ownRdata;

endmodule

// ==== rtl/ahbSlavePort.sv ====
/* AHB switch slave port
   Arbitrates the master layers by priority, drives the slave, tracks the data-phase owner */
module ahbSlavePort
  import ahbSwitchPkg::*;
#(
  // Position of this port in the layer return arrays
  parameter int slvIdx = 0
)
(
  input  logic   HCLK,
  input  logic   rstN,

  // All master layers
  ahbLayerIf.slave layers [nMasters],

  // AHB slave side
  output logic   hsel,
  output addrT   haddr,
  output dataT   hwdata,
  output logic   hwrite,
  output sizeT   hsize,
  output htransT htrans,
  output logic   hreadyOut,
  input  dataT   hrdata,
  input  logic   hready,
  input  hrespT  hresp
);

  mstSelT req;
  mstSelT arbWin;
  mstSelT grant;
  // Layer that owns the current data phase
  mstSelT ownQ;

  prioT   mPrio  [nMasters];
  addrT   mAddr  [nMasters];
  dataT   mWdata [nMasters];
  logic   mWrite [nMasters];
  sizeT   mSize  [nMasters];

  //////////////////////////////
  // Layer fan-in and fan-out
  //////////////////////////////

  for (genvar m = 0; m < nMasters; m++)
  begin : genLayer
    // Valid only once the layer's own previous data phase is over
    assign req[m]    = layers[m].reqSel[slvIdx] && (layers[m].trans == NONSEQ) &&
                       layers[m].busReady;
    assign mPrio[m]  = layers[m].prio;
    assign mAddr[m]  = layers[m].addr;
    assign mWdata[m] = layers[m].wdata;
    assign mWrite[m] = layers[m].write;
    assign mSize[m]  = layers[m].size;

    // Same slave response goes to every layer, grant tells who owns it
    assign layers[m].grant[slvIdx]    = grant[m];
    assign layers[m].rdata[slvIdx]    = hrdata;
    assign layers[m].readyOut[slvIdx] = hready;
    assign layers[m].resp[slvIdx]     = hresp;
  end

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  // Highest priority wins, strict compare keeps the lower index on a tie
  always_comb
  begin : arbitrate
    logic found;
    prioT bestPrio;
    arbWin   = '0;
    found    = 1'b0;
    bestPrio = '0;
    for (int m = 0; m < nMasters; m++)
    begin
      if (req[m] && (!found || mPrio[m] > bestPrio))
      begin
        arbWin    = '0;
        arbWin[m] = 1'b1;
        found     = 1'b1;
        bestPrio  = mPrio[m];
      end
    end
  end

  // Grant moves only when the slave's data phase ends
  // While stalled it stays with the data-phase owner
  assign grant = hready ? arbWin : ownQ;

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
      ownQ <= '0;
    else if (hready)
      ownQ <= arbWin;
  end

  //////////////////////////////
  // Slave-side buses
  //////////////////////////////

  // Address phase straight from the granted layer
  always_comb
  begin
    hsel   = 1'b0;
    haddr  = '0;
    hwrite = 1'b0;
    hsize  = '0;
    for (int m = 0; m < nMasters; m++)
    begin
      if (grant[m] && req[m])
      begin
        hsel   = 1'b1;
        haddr  = mAddr[m];
        hwrite = mWrite[m];
        hsize  = mSize[m];
      end
    end
    htrans = hsel ? NONSEQ : IDLE;
  end

  // Write data follows the data-phase owner
  always_comb
  begin
    hwdata = '0;
    for (int m = 0; m < nMasters; m++)
    begin
      if (ownQ[m])
        hwdata = mWdata[m];
    end
  end

  // One data phase at a time on this port, slave ready is the bus HREADY
  assign hreadyOut = hready;

endmodule

// ==== rtl/ahbSwitch.sv ====
/* AHB3-Lite two-by-two multi-layer switch
   Master layers and slave ports joined by one layer bus per master */
module ahbSwitch
  import ahbSwitchPkg::*;
(
  input  logic   HCLK,
  input  logic   rstN,

  // AHB masters connect here
  input  prioT   mstPriority  [nMasters],
  input  logic   mstHsel      [nMasters],
  input  addrT   mstHaddr     [nMasters],
  input  dataT   mstHwdata    [nMasters],
  input  logic   mstHwrite    [nMasters],
  input  sizeT   mstHsize     [nMasters],
  input  htransT mstHtrans    [nMasters],
  input  logic   mstHready    [nMasters],
  output dataT   mstHrdata    [nMasters],
  output logic   mstHreadyOut [nMasters],
  output hrespT  mstHresp     [nMasters],

  // Address window of each slave
  input  addrT   slvAddrMask  [nSlaves],
  input  addrT   slvAddrBase  [nSlaves],

  // AHB slaves connect here
  output logic   slvHsel      [nSlaves],
  output addrT   slvHaddr     [nSlaves],
  output dataT   slvHwdata    [nSlaves],
  output logic   slvHwrite    [nSlaves],
  output sizeT   slvHsize     [nSlaves],
  output htransT slvHtrans    [nSlaves],
  output logic   slvHreadyOut [nSlaves],
  input  dataT   slvHrdata    [nSlaves],
  input  logic   slvHready    [nSlaves],
  input  hrespT  slvHresp     [nSlaves]
);

  // One bus per master layer, seen by every slave port
  ahbLayerIf layerBus [nMasters] ();

  //////////////////////////////
  // Master layers
  //////////////////////////////

  for (genvar m = 0; m < nMasters; m++)
  begin : genMaster
    ahbMasterPort uMasterPort (
      .HCLK      (HCLK),
      .rstN      (rstN),
      .prio      (mstPriority[m]),
      .hsel      (mstHsel[m]),
      .haddr     (mstHaddr[m]),
      .hwdata    (mstHwdata[m]),
      .hwrite    (mstHwrite[m]),
      .hsize     (mstHsize[m]),
      .htrans    (mstHtrans[m]),
      .hready    (mstHready[m]),
      .hrdata    (mstHrdata[m]),
      .hreadyOut (mstHreadyOut[m]),
      .hresp     (mstHresp[m]),
      .addrMask  (slvAddrMask),
      .addrBase  (slvAddrBase),
      .bus       (layerBus[m])
    );
  end

  //////////////////////////////
  // Slave ports
  //////////////////////////////

  for (genvar s = 0; s < nSlaves; s++)
  begin : genSlave
    ahbSlavePort #(
      .slvIdx (s)
    ) uSlavePort (
      .HCLK      (HCLK),
      .rstN      (rstN),
      .layers    (layerBus),
      .hsel      (slvHsel[s]),
      .haddr     (slvHaddr[s]),
      .hwdata    (slvHwdata[s]),
      .hwrite    (slvHwrite[s]),
      .hsize     (slvHsize[s]),
      .htrans    (slvHtrans[s]),
      .hreadyOut (slvHreadyOut[s]),
      .hrdata    (slvHrdata[s]),
      .hready    (slvHready[s]),
      .hresp     (slvHresp[s])
    );
  end

endmodule

// ==== bench/ahbSlaveModel.sv ====
/* Behavioral AHB memory slave for the switch testbench
   Word memory that stretches each data phase by zero to two random wait states */
module ahbSlaveModel
  import ahbSwitchPkg::*;
(
  input  logic   HCLK,
  input  logic   rstN,
  input  logic   hsel,
  input  addrT   haddr,
  input  dataT   hwdata,
  input  logic   hwrite,
  input  htransT htrans,
  input  logic   hreadyIn,
  output dataT   hrdata,
  output logic   hreadyOut,
  output hrespT  hresp
);

  // 256 words, indexed by HADDR[9:2]
  dataT       mem [256];

  // Data phase in flight and its captured address phase
  logic       pending;
  addrT       addrQ;
  logic       writeQ;
  // Wait states still to insert before the data phase ends
  logic [1:0] waitsLeft;

  logic       addrPhase;

  assign addrPhase = hsel && hreadyIn && (htrans == NONSEQ);

  // Ready again once the wait count has run out
  assign hreadyOut = (waitsLeft == 2'd0);
  assign hresp     = OKAY;
  // Read data from the captured word, zero when no read is in flight
  assign hrdata    = (pending && !writeQ) ? mem[addrQ[9:2]] : '0;

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      pending   <= 1'b0;
      addrQ     <= '0;
      writeQ    <= 1'b0;
      waitsLeft <= '0;
    end
    else if (!hreadyOut)
      waitsLeft <= waitsLeft - 2'd1;
    else
    begin
      // Write lands in the last cycle of its data phase
      if (pending && writeQ)
        mem[addrQ[9:2]] <= hwdata;
      pending <= addrPhase;
      if (addrPhase)
      begin
        addrQ     <= haddr;
        writeQ    <= hwrite;
        waitsLeft <= 2'($urandom_range(2, 0));
      end
    end
  end

endmodule

// ==== bench/tbAhbSwitch.sv ====
/* Testbench for the two-by-two AHB switch
   Two master drivers and two memory slave models around the DUT */
module tbAhbSwitch
  import ahbSwitchPkg::*;
();

  // Roughly 60 transfers of up to a dozen cycles each fit well inside this limit
  localparam int timeoutCycles = 4000;

  logic   HCLK;
  logic   rstN;

  prioT   mstPriority  [nMasters];
  logic   mstHsel      [nMasters];
  addrT   mstHaddr     [nMasters];
  dataT   mstHwdata    [nMasters];
  logic   mstHwrite    [nMasters];
  sizeT   mstHsize     [nMasters];
  htransT mstHtrans    [nMasters];
  logic   mstHready    [nMasters];
  dataT   mstHrdata    [nMasters];
  logic   mstHreadyOut [nMasters];
  hrespT  mstHresp     [nMasters];

  addrT   slvAddrMask  [nSlaves];
  addrT   slvAddrBase  [nSlaves];

  logic   slvHsel      [nSlaves];
  addrT   slvHaddr     [nSlaves];
  dataT   slvHwdata    [nSlaves];
  logic   slvHwrite    [nSlaves];
  sizeT   slvHsize     [nSlaves];
  htransT slvHtrans    [nSlaves];
  logic   slvHreadyOut [nSlaves];
  dataT   slvHrdata    [nSlaves];
  logic   slvHready    [nSlaves];
  hrespT  slvHresp     [nSlaves];

  int     cycleCount;
  int     errorCount;
  // Errors found by the bus monitor
  int     monitorErrors;
  int     errorsAtStart;
  int     testsRun;
  int     testsFailed;
  int     waitSeen;
  string  testName;

  //////////////////////////////
  // DUT and slave models
  //////////////////////////////

  ahbSwitch u_dut (
    .HCLK         (HCLK),
    .rstN         (rstN),
    .mstPriority  (mstPriority),
    .mstHsel      (mstHsel),
    .mstHaddr     (mstHaddr),
    .mstHwdata    (mstHwdata),
    .mstHwrite    (mstHwrite),
    .mstHsize     (mstHsize),
    .mstHtrans    (mstHtrans),
    .mstHready    (mstHready),
    .mstHrdata    (mstHrdata),
    .mstHreadyOut (mstHreadyOut),
    .mstHresp     (mstHresp),
    .slvAddrMask  (slvAddrMask),
    .slvAddrBase  (slvAddrBase),
    .slvHsel      (slvHsel),
    .slvHaddr     (slvHaddr),
    .slvHwdata    (slvHwdata),
    .slvHwrite    (slvHwrite),
    .slvHsize     (slvHsize),
    .slvHtrans    (slvHtrans),
    .slvHreadyOut (slvHreadyOut),
    .slvHrdata    (slvHrdata),
    .slvHready    (slvHready),
    .slvHresp     (slvHresp)
  );

  for (genvar s = 0; s < nSlaves; s++)
  begin : genMem
    ahbSlaveModel uMem (
      .HCLK      (HCLK),
      .rstN      (rstN),
      .hsel      (slvHsel[s]),
      .haddr     (slvHaddr[s]),
      .hwdata    (slvHwdata[s]),
      .hwrite    (slvHwrite[s]),
      .htrans    (slvHtrans[s]),
      .hreadyIn  (slvHreadyOut[s]),
      .hrdata    (slvHrdata[s]),
      .hreadyOut (slvHready[s]),
      .hresp     (slvHresp[s])
    );
  end

  // A master alone on its layer gets the layer's HREADYOUT as its bus HREADY
  for (genvar m = 0; m < nMasters; m++)
  begin : genReady
    assign mstHready[m] = mstHreadyOut[m];
  end

  //////////////////////////////
  // Clock, timeout, monitor
  //////////////////////////////

  always #5 HCLK = ~HCLK;

  always @(posedge HCLK)
  begin
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("FAIL: see errors above");
      $finish;
    end
    else
      cycleCount++;
  end

  // Bus monitor on every slave port
  always @(negedge HCLK)
  begin
    for (int s = 0; s < nSlaves; s++)
    begin
      // A selected slave owns the address it sees
      if (rstN && slvHsel[s])
      begin
        assert (slaveFor(slvHaddr[s]) == s)
        else
        begin
          $display("** Error [%s] slave owning HADDR %h: expected %0d, actual %0d",
                   testName, slvHaddr[s], s, slaveFor(slvHaddr[s]));
          monitorErrors++;
        end
      end
      // A slave alone on its bus sees its own HREADYOUT as HREADY
      if (rstN)
      begin
        assert (slvHreadyOut[s] === slvHready[s])
        else
        begin
          $display("** Error [%s] HREADY into slave %0d: expected %b, actual %b",
                   testName, s, slvHready[s], slvHreadyOut[s]);
          monitorErrors++;
        end
      end
    end
  end

  //////////////////////////////
  // Checks and helpers
  //////////////////////////////

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("** Error [%s] %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    assert (actual === expected)
    else
    begin
      $display("** Error [%s] %s: expected %b, actual %b", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  // Slave 0 owns 0x0xxx_xxxx and slave 1 owns 0x1xxx_xxxx
  function automatic int slaveFor(input addrT addr);
    case (addr[31:28])
      4'h0:    return 0;
      4'h1:    return 1;
      default: return -1;
    endcase
  endfunction

  // Master whose data phase ended first or -1 on a draw
  function automatic int firstDone(input int end0, input int end1);
    if (end0 < end1)
      return 0;
    else if (end1 < end0)
      return 1;
    return -1;
  endfunction

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount + monitorErrors;
  endtask

  task automatic finishTest();
    int found;
    found = errorCount + monitorErrors - errorsAtStart;
    testsRun++;
    if (found != 0)
      testsFailed++;
    $display("Test %s: %s (%0d errors)", testName, (found == 0) ? "ok" : "failed", found);
  endtask

  // Address phase of this transfer taken by slave s in the current cycle
  task automatic watchAddrPhase(input int s, input addrT addr, input logic write,
                                input sizeT size, inout logic granted);
    if (slvHsel[s] && slvHready[s] && slvHaddr[s] == addr)
    begin
      granted = 1'b1;
      checkBit("slave HWRITE", write, slvHwrite[s]);
      checkValue("slave HSIZE", 32'(size), 32'(slvHsize[s]));
    end
  endtask

  // One single NONSEQ transfer on master m that starts right after a rising edge
  task automatic ahbTransfer(input int m, input addrT addr, input logic write,
                             input dataT wdata, output dataT rdata, output int endCycle);
    int   s;
    int   dataCycles;
    sizeT size;
    logic granted;
    logic done;
    s          = slaveFor(addr);
    dataCycles = 0;
    // Sizes up to a word on word addresses, which the model stores whole
    size       = sizeT'($urandom_range(2, 0));
    granted    = 1'b0;
    done       = 1'b0;
    mstHsel[m]   <= 1'b1;
    mstHaddr[m]  <= addr;
    mstHwrite[m] <= write;
    mstHsize[m]  <= size;
    mstHtrans[m] <= NONSEQ;
    // Address phase
    while (!done)
    begin
      @(negedge HCLK);
      if (s < 0)
        checkBit("HSEL on unmapped access", 1'b0, slvHsel[0] || slvHsel[1]);
      else
        watchAddrPhase(s, addr, write, size, granted);
      done = mstHreadyOut[m];
    end
    @(posedge HCLK);
    mstHsel[m]   <= 1'b0;
    mstHtrans[m] <= IDLE;
    mstHwdata[m] <= wdata;
    done = 1'b0;
    // Data phase lasts until the first high HREADYOUT
    while (!done)
    begin
      @(negedge HCLK);
      dataCycles++;
      if (s < 0)
      begin
        checkBit("HSEL on unmapped access", 1'b0, slvHsel[0] || slvHsel[1]);
        checkBit("HREADYOUT in error response", dataCycles >= 2, mstHreadyOut[m]);
        checkBit("HRESP in error response", ERROR, mstHresp[m]);
      end
      else if (granted)
      begin
        checkBit("HREADYOUT against slave HREADY", slvHready[s], mstHreadyOut[m]);
        if (!slvHready[s])
          waitSeen++;
      end
      else
      begin
        // Slave still busy with the other layer
        checkBit("HREADYOUT while waiting for grant", 1'b0, mstHreadyOut[m]);
        watchAddrPhase(s, addr, write, size, granted);
      end
      done = mstHreadyOut[m];
    end
    if (s >= 0)
      checkBit("HRESP at end of data phase", OKAY, mstHresp[m]);
    rdata    = mstHrdata[m];
    endCycle = cycleCount;
    @(posedge HCLK);
  endtask

  // Both masters write the same slave in the same cycle and then read it back
  task automatic raceForSlave(input int s, input prioT p0, input prioT p1,
                              input int winner, input addrT offset);
    addrT addr0;
    dataT wd0;
    dataT wd1;
    dataT rd0;
    dataT rd1;
    int   end0;
    int   end1;
    addr0 = slvAddrBase[s] + offset;
    wd0   = $urandom;
    wd1   = $urandom;
    mstPriority[0] <= p0;
    mstPriority[1] <= p1;
    fork
      ahbTransfer(0, addr0, 1'b1, wd0, rd0, end0);
      ahbTransfer(1, addr0 + 32'h4, 1'b1, wd1, rd1, end1);
    join
    checkValue("first write to finish", winner, firstDone(end0, end1));
    fork
      ahbTransfer(0, addr0, 1'b0, '0, rd0, end0);
      ahbTransfer(1, addr0 + 32'h4, 1'b0, '0, rd1, end1);
    join
    checkValue("first read to finish", winner, firstDone(end0, end1));
    checkValue("master 0 read data", wd0, rd0);
    checkValue("master 1 read data", wd1, rd1);
  endtask

  // Write and read-back pairs to random slaves in a window of its own per master
  task automatic randomTraffic(input int m);
    int   s;
    addrT addr;
    dataT wd;
    dataT rd;
    int   endCycle;
    for (int i = 0; i < 8; i++)
    begin
      s    = $urandom_range(1, 0);
      addr = slvAddrBase[s] + 32'h100 + 32'(m * 64) + 32'(i * 4);
      wd   = $urandom;
      ahbTransfer(m, addr, 1'b1, wd, rd, endCycle);
      ahbTransfer(m, addr, 1'b0, '0, rd, endCycle);
      checkValue("read data under wait states", wd, rd);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    dataT wrData [nMasters][nSlaves];
    dataT rd;
    int   endCycle;
    void'($urandom(32'hf813_1627));
    HCLK          = 1'b0;
    rstN          = 1'b0;
    cycleCount    = 0;
    errorCount    = 0;
    monitorErrors = 0;
    errorsAtStart = 0;
    testsRun      = 0;
    testsFailed   = 0;
    waitSeen      = 0;
    testName      = "init";
    for (int m = 0; m < nMasters; m++)
    begin
      mstPriority[m] = '0;
      mstHsel[m]     = 1'b0;
      mstHaddr[m]    = '0;
      mstHwdata[m]   = '0;
      mstHwrite[m]   = 1'b0;
      mstHsize[m]    = 3'd2;
      mstHtrans[m]   = IDLE;
    end
    for (int s = 0; s < nSlaves; s++)
    begin
      slvAddrMask[s] = 32'hF000_0000;
      slvAddrBase[s] = 32'(s) << 28;
    end
    repeat (8) @(posedge HCLK);
    rstN <= 1'b1;

    startTest("reset");
    @(negedge HCLK);
    for (int m = 0; m < nMasters; m++)
    begin
      checkBit("HREADYOUT after reset", 1'b1, mstHreadyOut[m]);
      checkBit("HRESP after reset", OKAY, mstHresp[m]);
    end
    for (int s = 0; s < nSlaves; s++)
    begin
      checkBit("slave HSEL after reset", 1'b0, slvHsel[s]);
      checkValue("slave HTRANS after reset", 32'(IDLE), 32'(slvHtrans[s]));
    end
    @(posedge HCLK);
    finishTest();

    // Same offset on both slaves makes a wrong decode show up as wrong data
    startTest("write-read");
    for (int m = 0; m < nMasters; m++)
      for (int s = 0; s < nSlaves; s++)
      begin
        wrData[m][s] = $urandom;
        ahbTransfer(m, slvAddrBase[s] + 32'h40 + 32'(m * 4), 1'b1, wrData[m][s], rd, endCycle);
      end
    for (int m = 0; m < nMasters; m++)
      for (int s = 0; s < nSlaves; s++)
      begin
        ahbTransfer(m, slvAddrBase[s] + 32'h40 + 32'(m * 4), 1'b0, '0, rd, endCycle);
        checkValue("read data", wrData[m][s], rd);
      end
    finishTest();

    startTest("unmapped");
    ahbTransfer(0, 32'h2000_0000, 1'b0, '0, rd, endCycle);
    ahbTransfer(1, 32'h2000_0010, 1'b1, $urandom, rd, endCycle);
    finishTest();

    // Master 1 at the higher priority
    startTest("priority");
    raceForSlave(0, 1'b0, 1'b1, 1, 32'h80);
    finishTest();

    // Tie first and then each master on top in turn
    startTest("tie-swap");
    raceForSlave(1, 1'b0, 1'b0, 0, 32'hC0);
    raceForSlave(1, 1'b1, 1'b0, 0, 32'hD0);
    raceForSlave(1, 1'b0, 1'b1, 1, 32'hE0);
    finishTest();

    startTest("wait-states");
    waitSeen = 0;
    mstPriority[0] <= 1'b0;
    mstPriority[1] <= 1'b0;
    fork
      randomTraffic(0);
      randomTraffic(1);
    join
    checkBit("data phases stretched by slave waits", 1'b1, waitSeen > 0);
    finishTest();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", testsRun,
             testsRun - testsFailed, testsFailed, errorCount + monitorErrors);
    if (errorCount + monitorErrors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tb.f ====
rtl/ahbSwitchPkg.sv
rtl/ahbLayerIf.sv
rtl/ahbMasterPort.sv
rtl/ahbSlavePort.sv
rtl/ahbSwitch.sv
bench/ahbSlaveModel.sv
bench/tbAhbSwitch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the AHB switch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tbAhbSwitch -f tb.f -o simAhbSwitch

simOut=$(./obj_dir/simAhbSwitch)
echo "$simOut"

if grep -qx "PASS: all tests" <<< "$simOut"
then
  exit 0
fi
exit 1
